// ==== gat_cfg_pkg.sv ====
// ============================
// Datapath sizes and default dimensions of the Wh projection stage,
// shared by the engine, the FIFO and the result buffer
// ============================

package gat_cfg_pkg;

  // Signed feature and weight values
  localparam int DATA_WIDTH       = 8;

  // One accumulated Wh value, wraps modulo 2**20
  localparam int WH_DATA_WIDTH    = 20;

  // Default matrix shape, H row is 1 x FEATURE_IN, W is FEATURE_IN x FEATURE_OUT
  localparam int DEF_FEATURE_IN   = 8;
  localparam int DEF_FEATURE_OUT  = 4;

  // Rows held by the result buffer
  localparam int DEF_RESULT_DEPTH = 16;

  // Result row side fields
  localparam int NUM_NODE_WIDTH   = 8;

  // Index width for n entries, never below one bit
  function automatic int idx_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// ==== axil_pkg.sv ====
// ============================
// AXI4-Lite register map, response codes and the decoding of
// the write data word for weight and feature entries
// ============================

package axil_pkg;

  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXIL_DATA_WIDTH = 32;

  // ============================
  // Register map
  // ============================
  // CTRL bit 0 clears the result buffer and the node counter
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL     = 8'h00;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_NUM_NODE = 8'h04;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_WEIGHT   = 8'h08;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_FEATURE  = 8'h0C;
  // STATUS: [7:0] row count, [8] FIFO full, [9] buffer full
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS   = 8'h10;
  // RES_SEL: [15:8] row, [7:0] column
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_RES_SEL  = 8'h14;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_RES_DATA = 8'h18;
  // RES_INFO: [7:0] node count, [8] source flag
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_RES_INFO = 8'h1C;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Write data seen as a weight entry or as a feature entry
  typedef union packed {
    struct packed {
      logic [7:0] unused;
      logic [7:0] row;
      logic [7:0] col;
      logic [7:0] value;
    } weight_entry;
    struct packed {
      logic [23:0] unused;
      logic [7:0]  value;
    } feature_entry;
  } axil_wdata_u;

endpackage

// ==== feature_fifo.sv ====
// ============================
// Feature FIFO between the register block and the Wh engine
// ============================

module feature_fifo #(
  parameter int FIFO_DEPTH = 8,
  localparam int PTR_W     = gat_cfg_pkg::idx_w(FIFO_DEPTH),
  localparam int CNT_W     = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      push,
  input  logic signed [gat_cfg_pkg::DATA_WIDTH-1:0] push_data,
  input  logic                                      pop,
  output logic signed [gat_cfg_pkg::DATA_WIDTH-1:0] pop_data,
  output logic                                      empty,
  output logic                                      full
);
  import gat_cfg_pkg::*;

  logic signed [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             count;
  logic                         wr_en;
  logic                         rd_en;

  assign wr_en    = push && !full;
  assign rd_en    = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the last slot so any depth works
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== axil_regs.sv ====
// ============================
// AXI4-Lite slave of the Wh stage. Writes turn into weight writes,
// feature pushes and control; reads return status and results
// ============================

module axil_regs #(
  parameter int NUM_FEATURE_IN  = gat_cfg_pkg::DEF_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = gat_cfg_pkg::DEF_FEATURE_OUT,
  parameter int RESULT_DEPTH    = gat_cfg_pkg::DEF_RESULT_DEPTH,
  localparam int W_ROW_W        = gat_cfg_pkg::idx_w(NUM_FEATURE_IN),
  localparam int W_COL_W        = gat_cfg_pkg::idx_w(NUM_FEATURE_OUT),
  localparam int RD_ROW_W       = gat_cfg_pkg::idx_w(RESULT_DEPTH),
  localparam int CNT_W          = $clog2(RESULT_DEPTH + 1)
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // Write address, data and response
  input  logic [axil_pkg::AXIL_ADDR_WIDTH-1:0]        awaddr,
  input  logic                                        awvalid,
  output logic                                        awready,
  input  logic [axil_pkg::AXIL_DATA_WIDTH-1:0]        wdata,
  input  logic                                        wvalid,
  output logic                                        wready,
  output logic [1:0]                                  bresp,
  output logic                                        bvalid,
  input  logic                                        bready,
  // Read address and data
  input  logic [axil_pkg::AXIL_ADDR_WIDTH-1:0]        araddr,
  input  logic                                        arvalid,
  output logic                                        arready,
  output logic [axil_pkg::AXIL_DATA_WIDTH-1:0]        rdata,
  output logic [1:0]                                  rresp,
  output logic                                        rvalid,
  input  logic                                        rready,
  // Datapath status and result read port
  input  logic                                        fifo_full,
  input  logic [CNT_W-1:0]                            row_count,
  input  logic                                        buf_full,
  input  logic [axil_pkg::AXIL_DATA_WIDTH-1:0]        rd_value,
  input  logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0]      rd_num_node,
  input  logic                                        rd_src_flag,
  // Write side pulses and held settings
  output logic                                        weight_we,
  output logic [W_ROW_W-1:0]                          weight_row,
  output logic [W_COL_W-1:0]                          weight_col,
  output logic signed [gat_cfg_pkg::DATA_WIDTH-1:0]   weight_val,
  output logic                                        push,
  output logic signed [gat_cfg_pkg::DATA_WIDTH-1:0]   push_data,
  output logic                                        clear,
  output logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0]      num_node,
  output logic [RD_ROW_W-1:0]                         rd_row,
  output logic [W_COL_W-1:0]                          rd_col
);
  import gat_cfg_pkg::*;
  import axil_pkg::*;

  axil_wdata_u                wd;
  logic                       wr_is_feature;
  logic                       wr_accept;
  logic                       rd_accept;
  logic [AXIL_DATA_WIDTH-1:0] rd_mux;

  // Word aligned and inside the register window
  function automatic logic is_mapped(input logic [AXIL_ADDR_WIDTH-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= REG_RES_INFO);
  endfunction

  // ============================
  // Write channel
  // ============================
  assign wd            = wdata;
  assign wr_is_feature = (awaddr == REG_FEATURE);

  // Address and data together, one response at a time, FIFO back-pressure
  assign wr_accept = awvalid && wvalid && !bvalid && !(wr_is_feature && fifo_full);
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign weight_we  = wr_accept && (awaddr == REG_WEIGHT);
  assign weight_row = wd.weight_entry.row[W_ROW_W-1:0];
  assign weight_col = wd.weight_entry.col[W_COL_W-1:0];
  assign weight_val = wd.weight_entry.value;
  assign push       = wr_accept && wr_is_feature;
  assign push_data  = wd.feature_entry.value;
  assign clear      = wr_accept && (awaddr == REG_CTRL) && wdata[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
      num_node <= '0;
      rd_row   <= '0;
      rd_col   <= '0;
    end else begin
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_accept) begin
        bvalid <= 1'b1;
        bresp  <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        if (awaddr == REG_NUM_NODE) begin
          num_node <= wdata[NUM_NODE_WIDTH-1:0];
        end
        if (awaddr == REG_RES_SEL) begin
          rd_row <= wdata[8 +: RD_ROW_W];
          rd_col <= wdata[0 +: W_COL_W];
        end
      end
    end
  end

  // ============================
  // Read channel
  // ============================
  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;

  always_comb begin
    rd_mux = '0;
    case (araddr)
      REG_NUM_NODE: rd_mux[NUM_NODE_WIDTH-1:0] = num_node;
      REG_STATUS: begin
        rd_mux[CNT_W-1:0] = row_count;
        rd_mux[8]         = fifo_full;
        rd_mux[9]         = buf_full;
      end
      REG_RES_SEL: begin
        rd_mux[8 +: RD_ROW_W] = rd_row;
        rd_mux[0 +: W_COL_W]  = rd_col;
      end
      REG_RES_DATA: rd_mux = rd_value;
      REG_RES_INFO: begin
        rd_mux[NUM_NODE_WIDTH-1:0] = rd_num_node;
        rd_mux[8]                  = rd_src_flag;
      end
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
      rdata  <= '0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
      rresp  <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
      rdata  <= rd_mux;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

// ==== wh_engine.sv ====
// ============================
// Wh = H x W engine. One feature per pop is multiplied against the
// weight row and added into one accumulator per output column
// ============================

module wh_engine #(
  parameter int NUM_FEATURE_IN  = gat_cfg_pkg::DEF_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = gat_cfg_pkg::DEF_FEATURE_OUT,
  localparam int W_ROW_W        = gat_cfg_pkg::idx_w(NUM_FEATURE_IN),
  localparam int W_COL_W        = gat_cfg_pkg::idx_w(NUM_FEATURE_OUT)
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      weight_we,
  input  logic [W_ROW_W-1:0]                        weight_row,
  input  logic [W_COL_W-1:0]                        weight_col,
  input  logic signed [gat_cfg_pkg::DATA_WIDTH-1:0] weight_val,
  input  logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0]    num_node,
  input  logic                                      clear,
  input  logic signed [gat_cfg_pkg::DATA_WIDTH-1:0] pop_data,
  input  logic                                      empty,
  input  logic                                      buf_full,
  output logic                                      pop,
  output logic                                      row_we,
  output logic [NUM_FEATURE_OUT-1:0][gat_cfg_pkg::WH_DATA_WIDTH-1:0] row_data,
  output logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0]    row_num_node,
  output logic                                      row_src_flag
);
  import gat_cfg_pkg::*;

  logic signed [DATA_WIDTH-1:0]    weight_mem [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] prod       [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] acc        [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] acc_next   [NUM_FEATURE_OUT];
  logic [W_ROW_W-1:0]              idx;
  logic                            last_feat;
  logic [NUM_NODE_WIDTH-1:0]       node_cnt;
  logic [NUM_NODE_WIDTH:0]         node_cnt_inc;

  always_ff @(posedge clk) begin
    if (weight_we) begin
      weight_mem[weight_row][weight_col] <= weight_val;
    end
  end

  assign pop          = !empty && !buf_full;
  assign last_feat    = (idx == W_ROW_W'(NUM_FEATURE_IN - 1));
  assign node_cnt_inc = node_cnt + 1'b1;

  // ============================
  // Processing elements
  // ============================
  // First product of a row restarts the sum
  for (genvar c = 0; c < NUM_FEATURE_OUT; c++) begin : g_pe
    assign prod[c]     = pop_data * weight_mem[idx][c];
    assign acc_next[c] = (idx == '0) ? prod[c] : acc[c] + prod[c];

    always_ff @(posedge clk) begin
      if (pop) begin
        acc[c] <= acc_next[c];
      end
    end
  end

  // ============================
  // Row and node bookkeeping
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx      <= '0;
      node_cnt <= '0;
      row_we   <= 1'b0;
    end else begin
      row_we <= pop && last_feat;
      if (pop) begin
        idx <= last_feat ? '0 : idx + 1'b1;
      end
      // Node count wraps at num_node, clear restarts the subgraph
      if (clear) begin
        node_cnt <= '0;
      end else if (pop && last_feat) begin
        node_cnt <= (node_cnt_inc >= num_node) ? '0 : node_cnt_inc[NUM_NODE_WIDTH-1:0];
      end
    end
  end

  // Finished row, valid while row_we is high
  always_ff @(posedge clk) begin
    if (pop && last_feat) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        row_data[c] <= acc_next[c];
      end
      row_num_node <= num_node;
      row_src_flag <= (node_cnt == '0);
    end
  end

endmodule

// ==== wh_result_buf.sv ====
// ============================
// Result buffer of finished Wh rows, read one value at a time
// ============================

module wh_result_buf #(
  parameter int NUM_FEATURE_OUT = gat_cfg_pkg::DEF_FEATURE_OUT,
  parameter int RESULT_DEPTH    = gat_cfg_pkg::DEF_RESULT_DEPTH,
  localparam int W_COL_W        = gat_cfg_pkg::idx_w(NUM_FEATURE_OUT),
  localparam int RD_ROW_W       = gat_cfg_pkg::idx_w(RESULT_DEPTH),
  localparam int CNT_W          = $clog2(RESULT_DEPTH + 1)
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic                                   row_we,
  input  logic [NUM_FEATURE_OUT-1:0][gat_cfg_pkg::WH_DATA_WIDTH-1:0] row_data,
  input  logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0] row_num_node,
  input  logic                                   row_src_flag,
  input  logic [RD_ROW_W-1:0]                    rd_row,
  input  logic [W_COL_W-1:0]                     rd_col,
  output logic [CNT_W-1:0]                       row_count,
  output logic                                   buf_full,
  output logic [axil_pkg::AXIL_DATA_WIDTH-1:0]   rd_value,
  output logic [gat_cfg_pkg::NUM_NODE_WIDTH-1:0] rd_num_node,
  output logic                                   rd_src_flag
);
  import gat_cfg_pkg::*;
  import axil_pkg::*;

  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] data_mem [RESULT_DEPTH];
  logic [NUM_NODE_WIDTH-1:0]                     node_mem [RESULT_DEPTH];
  logic                                          flag_mem [RESULT_DEPTH];
  logic [WH_DATA_WIDTH-1:0]                      sel_value;
  logic                                          wr_en;

  assign buf_full = (row_count == CNT_W'(RESULT_DEPTH));
  assign wr_en    = row_we && !buf_full;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[row_count[RD_ROW_W-1:0]] <= row_data;
      node_mem[row_count[RD_ROW_W-1:0]] <= row_num_node;
      flag_mem[row_count[RD_ROW_W-1:0]] <= row_src_flag;
    end
  end

  // Clear wins over a row landing in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_count <= '0;
    end else if (clear) begin
      row_count <= '0;
    end else if (wr_en) begin
      row_count <= row_count + 1'b1;
    end
  end

  // Sign extended to the bus width
  assign sel_value   = data_mem[rd_row][rd_col];
  assign rd_value    = {{(AXIL_DATA_WIDTH - WH_DATA_WIDTH){sel_value[WH_DATA_WIDTH-1]}},
                        sel_value};
  assign rd_num_node = node_mem[rd_row];
  assign rd_src_flag = flag_mem[rd_row];

endmodule

// ==== gat_wh_top.sv ====
// ============================
// Top of the Wh projection stage, an AXI4-Lite slave in front of
// the feature FIFO, the Wh engine and the result buffer
// ============================

module gat_wh_top #(
  parameter int NUM_FEATURE_IN  = gat_cfg_pkg::DEF_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = gat_cfg_pkg::DEF_FEATURE_OUT,
  parameter int RESULT_DEPTH    = gat_cfg_pkg::DEF_RESULT_DEPTH,
  parameter int FIFO_DEPTH      = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [axil_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axil_pkg::AXIL_DATA_WIDTH-1:0] wdata,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [axil_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [axil_pkg::AXIL_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready
);
  import gat_cfg_pkg::*;
  import axil_pkg::*;

  localparam int W_ROW_W  = idx_w(NUM_FEATURE_IN);
  localparam int W_COL_W  = idx_w(NUM_FEATURE_OUT);
  localparam int RD_ROW_W = idx_w(RESULT_DEPTH);
  localparam int CNT_W    = $clog2(RESULT_DEPTH + 1);

  logic                                          weight_we;
  logic [W_ROW_W-1:0]                            weight_row;
  logic [W_COL_W-1:0]                            weight_col;
  logic signed [DATA_WIDTH-1:0]                  weight_val;
  logic                                          push;
  logic signed [DATA_WIDTH-1:0]                  push_data;
  logic                                          clear;
  logic [NUM_NODE_WIDTH-1:0]                     num_node;
  logic                                          pop;
  logic signed [DATA_WIDTH-1:0]                  pop_data;
  logic                                          empty;
  logic                                          fifo_full;
  logic                                          row_we;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] row_data;
  logic [NUM_NODE_WIDTH-1:0]                     row_num_node;
  logic                                          row_src_flag;
  logic [CNT_W-1:0]                              row_count;
  logic                                          buf_full;
  logic [RD_ROW_W-1:0]                           rd_row;
  logic [W_COL_W-1:0]                            rd_col;
  logic [AXIL_DATA_WIDTH-1:0]                    rd_value;
  logic [NUM_NODE_WIDTH-1:0]                     rd_num_node;
  logic                                          rd_src_flag;

  // ============================
  // Input side
  // ============================
  axil_regs #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .RESULT_DEPTH    (RESULT_DEPTH)
  ) u_axil_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .fifo_full, .row_count, .buf_full, .rd_value, .rd_num_node, .rd_src_flag,
    .weight_we, .weight_row, .weight_col, .weight_val,
    .push, .push_data, .clear, .num_node, .rd_row, .rd_col
  );

  feature_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_feature_fifo (
    .clk, .rst_n, .push, .push_data, .pop, .pop_data, .empty,
    .full (fifo_full)
  );

  // ============================
  // Processing and output side
  // ============================
  wh_engine #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_wh_engine (
    .clk, .rst_n, .weight_we, .weight_row, .weight_col, .weight_val,
    .num_node, .clear, .pop_data, .empty, .buf_full,
    .pop, .row_we, .row_data, .row_num_node, .row_src_flag
  );

  wh_result_buf #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .RESULT_DEPTH    (RESULT_DEPTH)
  ) u_wh_result_buf (
    .clk, .rst_n, .clear, .row_we, .row_data, .row_num_node, .row_src_flag,
    .rd_row, .rd_col, .row_count, .buf_full, .rd_value, .rd_num_node, .rd_src_flag
  );

endmodule

// ==== gat_wh_properties.sv ====
// ============================
// Concurrent checks on the AXI4-Lite handshake and the result
// buffer flags, bound into the register block and the buffer
// ============================

module gat_wh_properties #(
  parameter int RESULT_DEPTH = gat_cfg_pkg::DEF_RESULT_DEPTH
) (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              awvalid,
  input logic                              awready,
  input logic                              wvalid,
  input logic                              wready,
  input logic                              bvalid,
  input logic                              arvalid,
  input logic                              arready,
  input logic [$clog2(RESULT_DEPTH+1)-1:0] row_count,
  input logic                              buf_full,
  input logic                              row_we
);

  // A raised valid stays up until its ready
  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");

  // Write response only for an accepted write
  a_b_after_w: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else $error("bvalid raised without an accepted write");

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    row_count <= RESULT_DEPTH) else $error("row count above buffer depth");
  a_no_we_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(row_we && buf_full)) else $error("row write while buffer full");

endmodule

// ==== tb_gat_wh.sv ====
// ============================
// Testbench of the Wh projection stage. Drives the AXI4-Lite port and
// checks every result row against a reference model of H x W
// ============================

module tb_gat_wh;
  import axil_pkg::*;

  localparam int NUM_FEATURE_IN  = 8;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int RESULT_DEPTH    = 16;
  localparam int FIFO_DEPTH      = 8;
  // About four times the length of all tests
  localparam int MAX_CYCLES      = 4000;

  logic        clk;
  logic        rst_n;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Reference copy of the weights and the row being sent
  logic signed [7:0] w_ref [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  logic signed [7:0] cur_feat [NUM_FEATURE_IN];
  // Expected results, four values then one info word per row
  logic [31:0]       exp_data [$];
  logic [31:0]       exp_info [$];
  int                num_node    = 1;
  int                node_idx    = 0;
  int                rd_next     = 0;
  int                seed        = 32'hacaf;
  int                cycle_count = 0;
  bit                wr_lock     = 1'b0;
  string             test_name   = "reset";

  gat_wh_top #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .RESULT_DEPTH    (RESULT_DEPTH),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) u_gat_wh_top (
    .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
    .rvalid, .rready
  );

  // Handshake and count checks inside the register block
  bind axil_regs gat_wh_properties #(.RESULT_DEPTH (RESULT_DEPTH)) u_axil_props (
    .clk, .rst_n, .awvalid, .awready, .wvalid, .wready, .bvalid, .arvalid,
    .arready, .row_count, .buf_full, .row_we (1'b0)
  );

  // Row write against the full flag inside the buffer
  bind wh_result_buf gat_wh_properties #(.RESULT_DEPTH (RESULT_DEPTH)) u_buf_props (
    .clk, .rst_n, .awvalid (1'b0), .awready (1'b0), .wvalid (1'b0), .wready (1'b0),
    .bvalid (1'b0), .arvalid (1'b0), .arready (1'b0), .row_count, .buf_full, .row_we
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Done: errors found");
      $fatal(1, "Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  // ============================
  // AXI4-Lite access
  // ============================
  // Write channel is shared by the stimulus and the comparison process
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    while (wr_lock) begin
      @(negedge clk);
    end
    wr_lock = 1'b1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Address and data move together on the edge where both readies are high
    do begin
      @(posedge clk);
    end while (!(awready && wready));
    // Response comes one cycle after the accepting edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wr_lock = 1'b0;
    check_value({test_name, " write response valid"}, 32'd1, 32'(bvalid));
    check_value({test_name, " write response"}, 32'(RESP_OKAY), 32'(bresp));
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    // Read data one cycle after the address is taken
    @(negedge clk);
    arvalid = 1'b0;
    check_value({test_name, " read data valid"}, 32'd1, 32'(rvalid));
    data    = rdata;
    resp    = rresp;
  endtask

  // ============================
  // Reference model
  // ============================
  // Signed dot product of the row with one weight column, 20-bit wrap
  function automatic logic [31:0] ref_wh(input int col);
    int          sum;
    int          i;
    logic [19:0] wrapped;
    sum = 0;
    for (i = 0; i < NUM_FEATURE_IN; i++) begin
      sum += int'(cur_feat[i]) * int'(w_ref[i][col]);
    end
    wrapped = sum[19:0];
    return {{12{wrapped[19]}}, wrapped};
  endfunction

  // Nodes counted modulo num_node from zero after a clear
  function automatic void expect_row();
    int c;
    for (c = 0; c < NUM_FEATURE_OUT; c++) begin
      exp_data.push_back(ref_wh(c));
    end
    exp_info.push_back({23'b0, node_idx == 0, 8'(num_node)});
    node_idx = (node_idx + 1) % num_node;
  endfunction

  // ============================
  // Stimulus helpers
  // ============================
  task automatic load_weights(input bit extreme);
    int i;
    int j;
    for (i = 0; i < NUM_FEATURE_IN; i++) begin
      for (j = 0; j < NUM_FEATURE_OUT; j++) begin
        if (extreme) begin
          w_ref[i][j] = (j < NUM_FEATURE_OUT / 2) ? 8'sh80 : 8'sh7f;
        end else begin
          w_ref[i][j] = 8'($random(seed));
        end
        axi_write(REG_WEIGHT, {8'h00, 8'(i), 8'(j), w_ref[i][j]});
      end
    end
  endtask

  function automatic void random_row();
    int i;
    for (i = 0; i < NUM_FEATURE_IN; i++) begin
      cur_feat[i] = 8'($random(seed));
    end
  endfunction

  task automatic write_row();
    int i;
    for (i = 0; i < NUM_FEATURE_IN; i++) begin
      axi_write(REG_FEATURE, {24'h0, cur_feat[i]});
    end
  endtask

  task automatic send_random_row();
    random_row();
    expect_row();
    write_row();
  endtask

  task automatic wait_drained();
    while (exp_info.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Only called while the comparison process is idle
  task automatic clear_results();
    axi_write(REG_CTRL, 32'h1);
    node_idx = 0;
    rd_next  = 0;
  endtask

  // ============================
  // Comparison process
  // ============================
  initial begin : compare_results
    logic [31:0] value;
    logic [1:0]  resp;
    int          col;
    forever begin
      while (exp_info.size() == 0) begin
        @(negedge clk);
      end
      axi_read(REG_STATUS, value, resp);
      if (int'(value[7:0]) > rd_next) begin
        for (col = 0; col < NUM_FEATURE_OUT; col++) begin
          axi_write(REG_RES_SEL, 32'((rd_next << 8) | col));
          axi_read(REG_RES_DATA, value, resp);
          check_value($sformatf("%s row %0d col %0d resp", test_name, rd_next, col),
                      32'(RESP_OKAY), 32'(resp));
          check_value($sformatf("%s row %0d col %0d", test_name, rd_next, col),
                      exp_data.pop_front(), value);
        end
        axi_read(REG_RES_INFO, value, resp);
        check_value($sformatf("%s row %0d info resp", test_name, rd_next),
                    32'(RESP_OKAY), 32'(resp));
        check_value($sformatf("%s row %0d info", test_name, rd_next), exp_info[0], value);
        void'(exp_info.pop_front());
        rd_next++;
      end
    end
  end

  // ============================
  // Test sequence
  // ============================
  initial begin : run_tests
    logic [31:0] value;
    logic [1:0]  resp;
    int          r;
    int          i;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Random weights, subgraphs of three nodes
    test_name = "random rows";
    load_weights(1'b0);
    num_node = 3;
    axi_write(REG_NUM_NODE, 32'd3);
    clear_results();
    for (r = 0; r < 6; r++) begin
      send_random_row();
    end
    wait_drained();

    // Largest magnitudes on both operands
    test_name = "extreme values";
    load_weights(1'b1);
    clear_results();
    for (r = 0; r < 2; r++) begin
      for (i = 0; i < NUM_FEATURE_IN; i++) begin
        cur_feat[i] = (r == 0) ? 8'sh80 : 8'sh7f;
      end
      expect_row();
      write_row();
    end
    wait_drained();

    // Buffer fills, engine stops and the FIFO backs up
    test_name = "full buffer";
    clear_results();
    for (r = 0; r < RESULT_DEPTH; r++) begin
      send_random_row();
    end
    wait_drained();
    random_row();
    write_row();
    axi_read(REG_STATUS, value, resp);
    check_value("full buffer status", 32'(RESULT_DEPTH) | 32'h300, value);
    // Held row lands first after the clear
    clear_results();
    expect_row();
    send_random_row();
    send_random_row();
    wait_drained();
    axi_read(REG_STATUS, value, resp);
    check_value("full buffer row count", 32'd3, value);

    // Unmapped offset and clear through REG_CTRL
    test_name = "control";
    axi_read(8'h20, value, resp);
    check_value("unmapped read response", 32'(RESP_SLVERR), 32'(resp));
    axi_write(REG_CTRL, 32'h1);
    axi_read(REG_STATUS, value, resp);
    check_value("row count after clear", 32'd0, 32'(value[7:0]));

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== files.f ====
gat_cfg_pkg.sv
axil_pkg.sv
feature_fifo.sv
axil_regs.sv
wh_engine.sv
wh_result_buf.sv
gat_wh_top.sv
gat_wh_properties.sv
tb_gat_wh.sv

// ==== run.sh ====
#!/bin/sh
# Build the Wh stage testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_gat_wh -o sim_gat_wh
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_gat_wh
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
